// File: hw/rvs_pkg.sv
package rvs_pkg;

    // Register index width. The ISA fixes this at five bits for x0 to x31.
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;

    // Operation codes as they leave decode. LI passes the immediate through
    // the ALU so that seeding a register uses the same result path.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,  // Signed compare that gives 1 or 0.
        ALU_SLTU = 4'd9,  // Unsigned compare.
        ALU_LI   = 4'd10
    } alu_op_t;

endpackage

// File: hw/rvs_pipe_ifs.sv
`timescale 1ns/1ps

// Registered operation handed from the operand stage to execute.
interface rvs_op_if #(
    parameter int XLEN = 64
);
    import rvs_pkg::*;

    logic                  valid; // One-cycle strobe per operation.
    alu_op_t               op;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       src1;  // Operands after forwarding.
    logic [XLEN-1:0]       src2;

    modport stage (
        output valid, op, rd, imm, src1, src2
    );

    modport exec (
        input  valid, op, rd, imm, src1, src2
    );

endinterface

// Forwarding bus from execute back to the operand stage.
// The ex half is combinational from the ALU, the mem half is registered.
interface rvs_fwd_if #(
    parameter int XLEN = 64
);
    import rvs_pkg::*;

    logic                  ex_valid;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [XLEN-1:0]       ex_res;
    logic                  mem_valid;
    logic [REG_ADDR_W-1:0] mem_rd;
    logic [XLEN-1:0]       mem_res;

    modport src  (output ex_valid, ex_rd, ex_res, mem_valid, mem_rd, mem_res);
    modport sink (input  ex_valid, ex_rd, ex_res, mem_valid, mem_rd, mem_res);

endinterface

// File: hw/rvs_regfile.sv
`timescale 1ns/1ps

module rvs_regfile #(
    parameter int XLEN = 64
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [rvs_pkg::REG_ADDR_W-1:0]  raddr1,
    input  logic [rvs_pkg::REG_ADDR_W-1:0]  raddr2,
    output logic [XLEN-1:0]                 rdata1,
    output logic [XLEN-1:0]                 rdata2,
    input  logic                            we,
    input  logic [rvs_pkg::REG_ADDR_W-1:0]  waddr,
    input  logic [XLEN-1:0]                 wdata
);
    import rvs_pkg::*;

    // x0 has no storage at all, so only x1 to x31 exist here.
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata; // Writes to x0 are dropped.
        end
    end

    // Reads are combinational. A write lands at the clock edge, and a reader
    // three issues later sees it, so there is no write-through path.
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

    // A write with an unknown index would corrupt an arbitrary register.
    a_waddr_known : assert property (
        @(posedge clk) disable iff (!rst_n) we |-> !$isunknown(waddr)
    ) else $error("regfile write with unknown address");

endmodule

// File: hw/rvs_operand_fwd.sv
`timescale 1ns/1ps

module rvs_operand_fwd #(
    parameter int XLEN = 64
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            issue_valid,
    input  rvs_pkg::alu_op_t                issue_op,
    input  logic [rvs_pkg::REG_ADDR_W-1:0]  issue_rs1,
    input  logic [rvs_pkg::REG_ADDR_W-1:0]  issue_rs2,
    input  logic [rvs_pkg::REG_ADDR_W-1:0]  issue_rd,
    input  logic [XLEN-1:0]                 issue_imm,
    input  logic [XLEN-1:0]                 rf_rdata1,
    input  logic [XLEN-1:0]                 rf_rdata2,
    rvs_fwd_if.sink                         fwd,
    rvs_op_if.stage                         op_out
);
    import rvs_pkg::*;

    logic [XLEN-1:0] src1_sel;
    logic [XLEN-1:0] src2_sel;

    // Picks the newest value of one source register. The operation now in
    // execute is younger than the one in memory, so it is checked first.
    function automatic logic [XLEN-1:0] pick_src(
        input logic [REG_ADDR_W-1:0] rs,
        input logic [XLEN-1:0]       rf_val
    );
        logic [XLEN-1:0] val;
        if (rs == '0) begin
            val = '0;                    // x0 always reads zero.
        end else if (fwd.ex_valid && (fwd.ex_rd == rs)) begin
            val = fwd.ex_res;
        end else if (fwd.mem_valid && (fwd.mem_rd == rs)) begin
            val = fwd.mem_res;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    // Each operand is resolved on its own, so both may forward at once.
    always_comb begin
        src1_sel = pick_src(issue_rs1, rf_rdata1);
        src2_sel = pick_src(issue_rs2, rf_rdata2);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_out.valid <= 1'b0;
            op_out.op    <= ALU_ADD;
            op_out.rd    <= '0;
            op_out.imm   <= '0;
            op_out.src1  <= '0;
            op_out.src2  <= '0;
        end else begin
            op_out.valid <= issue_valid;
            if (issue_valid) begin      // Payload only moves with an issue.
                op_out.op   <= issue_op;
                op_out.rd   <= issue_rd;
                op_out.imm  <= issue_imm;
                op_out.src1 <= src1_sel;
                op_out.src2 <= src2_sel;
            end
        end
    end

    // An unknown strobe here would spread through every later stage.
    a_valid_known : assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(op_out.valid)
    ) else $error("operand stage valid is unknown");

endmodule

// File: hw/rvs_exec_stage.sv
`timescale 1ns/1ps

module rvs_exec_stage #(
    parameter int XLEN = 64
) (
    input  logic                            clk,
    input  logic                            rst_n,
    rvs_op_if.exec                          op_in,
    rvs_fwd_if.src                          fwd,
    output logic                            we,
    output logic [rvs_pkg::REG_ADDR_W-1:0]  waddr,
    output logic [XLEN-1:0]                 wdata,
    output logic                            res_valid,
    output logic [rvs_pkg::REG_ADDR_W-1:0]  res_rd,
    output logic [XLEN-1:0]                 res_data
);
    import rvs_pkg::*;

    // Six shift bits at XLEN 64, five at XLEN 32.
    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0]    shamt;
    logic [XLEN-1:0]       alu_res;
    logic                  mem_valid;
    logic [REG_ADDR_W-1:0] mem_rd;
    logic [XLEN-1:0]       mem_res;

    assign shamt = op_in.src2[SHAMT_W-1:0];

    always_comb begin
        case (op_in.op)
            ALU_ADD:  alu_res = op_in.src1 + op_in.src2;
            ALU_SUB:  alu_res = op_in.src1 - op_in.src2;
            ALU_AND:  alu_res = op_in.src1 & op_in.src2;
            ALU_OR:   alu_res = op_in.src1 | op_in.src2;
            ALU_XOR:  alu_res = op_in.src1 ^ op_in.src2;
            ALU_SLL:  alu_res = op_in.src1 << shamt;
            ALU_SRL:  alu_res = op_in.src1 >> shamt;
            ALU_SRA:  alu_res = $signed(op_in.src1) >>> shamt;
            ALU_SLT: begin
                alu_res = {{(XLEN-1){1'b0}}, $signed(op_in.src1) < $signed(op_in.src2)};
            end
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_in.src1 < op_in.src2};
            ALU_LI:   alu_res = op_in.imm;
            default:  alu_res = '0;
        endcase
    end

    // Results bound for x0 are kept off the forwarding bus entirely.
    assign fwd.ex_valid = op_in.valid && (op_in.rd != '0);
    assign fwd.ex_rd    = op_in.rd;
    assign fwd.ex_res   = alu_res;

    // Memory stage. It only carries the result one cycle further.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
            mem_rd    <= '0;
            mem_res   <= '0;
        end else begin
            mem_valid <= op_in.valid;
            if (op_in.valid) begin
                mem_rd  <= op_in.rd;
                mem_res <= alu_res;
            end
        end
    end

    assign fwd.mem_valid = mem_valid && (mem_rd != '0);
    assign fwd.mem_rd    = mem_rd;
    assign fwd.mem_res   = mem_res;

    // Writeback happens from the memory register at the same edge that
    // loads the result outputs.
    assign we    = mem_valid && (mem_rd != '0);
    assign waddr = mem_rd;
    assign wdata = mem_res;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            res_rd    <= '0;
            res_data  <= '0;
        end else begin
            res_valid <= mem_valid;
            if (mem_valid) begin
                res_rd   <= mem_rd;
                res_data <= mem_res;
            end
        end
    end

    // An undefined code would quietly give zero through the default branch.
    a_op_defined : assert property (
        @(posedge clk) disable iff (!rst_n) op_in.valid |-> (op_in.op <= ALU_LI)
    ) else $error("undefined ALU operation reached execute");

endmodule

// File: hw/rvs_alu_pipe.sv
`timescale 1ns/1ps

module rvs_alu_pipe #(
    parameter int XLEN = 64
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            issue_valid,
    input  rvs_pkg::alu_op_t                issue_op,
    input  logic [rvs_pkg::REG_ADDR_W-1:0]  issue_rs1,
    input  logic [rvs_pkg::REG_ADDR_W-1:0]  issue_rs2,
    input  logic [rvs_pkg::REG_ADDR_W-1:0]  issue_rd,
    input  logic [XLEN-1:0]                 issue_imm,
    output logic                            res_valid,
    output logic [rvs_pkg::REG_ADDR_W-1:0]  res_rd,
    output logic [XLEN-1:0]                 res_data
);
    import rvs_pkg::*;

    logic [XLEN-1:0]       rf_rdata1;
    logic [XLEN-1:0]       rf_rdata2;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;

    rvs_op_if  #(.XLEN(XLEN)) op_bus  ();
    rvs_fwd_if #(.XLEN(XLEN)) fwd_bus ();

    // Source registers are read straight from the issue fields.
    rvs_regfile #(.XLEN(XLEN)) u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (issue_rs1),
        .raddr2 (issue_rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    rvs_operand_fwd #(.XLEN(XLEN)) u_operand_fwd (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_rd    (issue_rd),
        .issue_imm   (issue_imm),
        .rf_rdata1   (rf_rdata1),
        .rf_rdata2   (rf_rdata2),
        .fwd         (fwd_bus.sink),
        .op_out      (op_bus.stage)
    );

    rvs_exec_stage #(.XLEN(XLEN)) u_exec_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_in     (op_bus.exec),
        .fwd       (fwd_bus.src),
        .we        (rf_we),
        .waddr     (rf_waddr),
        .wdata     (rf_wdata),
        .res_valid (res_valid),
        .res_rd    (res_rd),
        .res_data  (res_data)
    );

endmodule

// File: bench/rvs_clk_gen.sv
`timescale 1ns/1ps

module rvs_clk_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk; // Half a period per phase.
        end
    end

endmodule

// File: bench/tb_rvs_alu_pipe.sv
`timescale 1ns/1ps

module tb_rvs_alu_pipe;
    import rvs_pkg::*;

    localparam int    XLEN          = 64;
    localparam int    LATENCY       = 3;  // Issue edge to result edge.
    localparam int    RESET_CYCLES  = 10;
    localparam int    DRAIN_TIMEOUT = 50;
    localparam string TESTS_FILE    = "bench/rvs_alu_pipe_tests.mem";

    logic                  clk;
    logic                  rst_n;
    logic                  issue_valid;
    alu_op_t               issue_op;
    logic [REG_ADDR_W-1:0] issue_rs1;
    logic [REG_ADDR_W-1:0] issue_rs2;
    logic [REG_ADDR_W-1:0] issue_rd;
    logic [XLEN-1:0]       issue_imm;
    logic                  res_valid;
    logic [REG_ADDR_W-1:0] res_rd;
    logic [XLEN-1:0]       res_data;

    int cyc = 0;         // Counts rising edges since time zero.
    int num_issued = 0;

    // Outstanding operations in issue order.
    logic [REG_ADDR_W-1:0] exp_rd_q[$];
    logic [XLEN-1:0]       exp_data_q[$];
    int                    issue_cyc_q[$];

    rvs_clk_gen #(.PERIOD_NS(4)) u_clk_gen (
        .clk (clk)
    );

    rvs_alu_pipe #(.XLEN(XLEN)) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_rd    (issue_rd),
        .issue_imm   (issue_imm),
        .res_valid   (res_valid),
        .res_rd      (res_rd),
        .res_data    (res_data)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] actual,
                               input logic [XLEN-1:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("error %s actual 0x%h expected 0x%h", name, actual, expected));
        end
    endtask

    // Compares one result with the oldest outstanding issue.
    task automatic check_result();
        logic [REG_ADDR_W-1:0] want_rd;
        logic [XLEN-1:0]       want_data;
        int                    issued_at;
        int                    latency;
        want_rd   = exp_rd_q.pop_front();
        want_data = exp_data_q.pop_front();
        issued_at = issue_cyc_q.pop_front();
        latency   = cyc - 1 - issued_at; // The outputs changed at the last rising edge.
        check_value("res_rd", XLEN'(res_rd), XLEN'(want_rd));
        check_value("res_data", res_data, want_data);
        check_value("latency", XLEN'(latency), XLEN'(LATENCY));
    endtask

    // Outputs are sampled at the falling edge, half a cycle after they settle.
    always @(negedge clk) begin
        if (!rst_n) begin
            check_value("res_valid", XLEN'(res_valid), '0);
        end else if (res_valid) begin
            if (exp_rd_q.size() == 0) begin
                fail_run("a result came out of the pipeline with no issue outstanding");
            end else begin
                check_result();
            end
        end
    end

    task automatic idle_cycles(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            issue_valid <= 1'b0;
        end
    endtask

    task automatic drive_issue(input logic [3:0] op, input logic [REG_ADDR_W-1:0] rs1,
                               input logic [REG_ADDR_W-1:0] rs2,
                               input logic [REG_ADDR_W-1:0] rd,
                               input logic [XLEN-1:0] imm, input logic [XLEN-1:0] expected);
        @(posedge clk);
        issue_valid <= 1'b1;
        issue_op    <= alu_op_t'(op);
        issue_rs1   <= rs1;
        issue_rs2   <= rs2;
        issue_rd    <= rd;
        issue_imm   <= imm;
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(expected);
        issue_cyc_q.push_back(cyc); // The count before the edge that launches the issue.
        num_issued++;
    endtask

    // Comment and blank lines match no field and are passed over.
    task automatic run_tests_file();
        int                    fd;
        int                    fields;
        string                 line;
        int                    idle;
        logic [3:0]            op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       expected;
        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            fail_run("the tests file could not be opened");
        end
        while ($fgets(line, fd) != 0) begin
            fields = $sscanf(line, "%d %h %d %d %d %h %h",
                             idle, op, rs1, rs2, rd, imm, expected);
            if (fields == 7) begin
                idle_cycles(idle);
                drive_issue(op, rs1, rs2, rd, imm, expected);
            end else if (fields > 0) begin
                fail_run($sformatf("the tests file has a malformed line: %s", line));
            end
        end
        $fclose(fd);
        if (num_issued == 0) begin
            fail_run("the tests file held no operations");
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_rd_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
    endtask

    initial begin
        rst_n       <= 1'b0;
        issue_valid <= 1'b0;
        issue_op    <= ALU_ADD;
        issue_rs1   <= '0;
        issue_rs2   <= '0;
        issue_rd    <= '0;
        issue_imm   <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        run_tests_file();
        idle_cycles(1);
        wait_for_drain();

        if (exp_rd_q.size() != 0) begin
            fail_run("some results never came out of the pipeline before the timeout");
        end else begin
            idle_cycles(4); // A stray result here is caught by the monitor.
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: rvs_alu_pipe.f
hw/rvs_pkg.sv
hw/rvs_pipe_ifs.sv
hw/rvs_regfile.sv
hw/rvs_operand_fwd.sv
hw/rvs_exec_stage.sv
hw/rvs_alu_pipe.sv
bench/rvs_clk_gen.sv
bench/tb_rvs_alu_pipe.sv

// File: Makefile
SIM  := obj_dir/Vtb_rvs_alu_pipe
SRCS := $(shell cat rvs_alu_pipe.f)

all: run

# The binary is rebuilt only when a source or the file list changes.
$(SIM): rvs_alu_pipe.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_rvs_alu_pipe \
		--Mdir obj_dir -f rvs_alu_pipe.f

# The exit status of the simulator is the result of the run.
run: $(SIM) bench/rvs_alu_pipe_tests.mem
	./$(SIM)

clean:
	rm -rf obj_dir

.PHONY: all run clean

// File: bench/rvs_alu_pipe_tests.mem
// Columns are idle cycles, op, rs1, rs2, rd, imm and the expected result.
// Idle, rs1, rs2 and rd are decimal. Op, imm and the expected result are hex.
4 a 0 0 1 0000000000000007 0000000000000007
0 a 0 0 2 0000000000000005 0000000000000005
0 a 0 0 3 fffffffffffffff0 fffffffffffffff0
0 a 0 0 4 8000000000000001 8000000000000001
0 a 0 0 5 00000000000000ff 00000000000000ff
2 0 1 2 6 0000000000000000 000000000000000c
2 1 2 1 7 0000000000000000 fffffffffffffffe
2 2 3 5 8 0000000000000000 00000000000000f0
2 3 1 3 9 0000000000000000 fffffffffffffff7
2 4 4 5 10 0000000000000000 80000000000000fe
2 5 1 2 11 0000000000000000 00000000000000e0
2 6 4 2 12 0000000000000000 0400000000000000
2 7 4 2 13 0000000000000000 fc00000000000000
2 8 3 1 14 0000000000000000 0000000000000001
2 9 3 1 15 0000000000000000 0000000000000000
2 5 1 3 16 0000000000000000 0007000000000000
2 a 0 0 17 0000000000000010 0000000000000010
0 0 17 1 18 0000000000000000 0000000000000017
0 1 2 18 19 0000000000000000 ffffffffffffffee
0 0 19 19 20 0000000000000000 ffffffffffffffdc
2 a 0 0 21 0000000000001000 0000000000001000
1 0 21 2 22 0000000000000000 0000000000001005
0 a 0 0 23 0000000000000003 0000000000000003
0 6 22 23 24 0000000000000000 0000000000000200
2 a 0 0 25 0000000000000aaa 0000000000000aaa
0 a 0 0 25 0000000000000555 0000000000000555
0 3 25 25 26 0000000000000000 0000000000000555
1 4 1 26 27 0000000000000000 0000000000000552
2 a 0 0 0 00000000deadbeef 00000000deadbeef
0 a 0 0 0 0000000000000123 0000000000000123
0 0 0 0 28 0000000000000000 0000000000000000
0 0 0 1 29 0000000000000000 0000000000000007
2 3 0 1 30 0000000000000000 0000000000000007
2 0 1 1 1 0000000000000000 000000000000000e
0 0 1 1 1 0000000000000000 000000000000001c
0 0 1 1 1 0000000000000000 0000000000000038
0 1 1 2 31 0000000000000000 0000000000000033
0 2 31 1 31 0000000000000000 0000000000000030
0 7 3 31 2 0000000000000000 ffffffffffffffff
0 9 2 1 3 0000000000000000 0000000000000000
0 8 2 3 4 0000000000000000 0000000000000001
